/* filelist.f */
design/cache_pkg.sv
design/array_if.sv
design/tag_array.sv
design/data_array.sv
design/cache_ctrl.sv
design/l2_cache.sv
tests/tb_l2_cache.sv

/* tests/cache_stimulus.txt */
// columns op_addr_wdata_rdata_writes_reads, op 0 read and 1 write
// read data of a line never written is the address in each 32 bit word
0_000100a_00000000000000000000000000000000_0000100a0000100a0000100a0000100a_0_1
0_000100a_00000000000000000000000000000000_0000100a0000100a0000100a0000100a_0_0
1_000100a_0123456789abcdef0011223344556677_00000000000000000000000000000000_0_0
0_000100a_00000000000000000000000000000000_0123456789abcdef0011223344556677_0_0
// lru in set 05
0_0000045_00000000000000000000000000000000_00000045000000450000004500000045_0_1
0_0000085_00000000000000000000000000000000_00000085000000850000008500000085_0_1
0_0000045_00000000000000000000000000000000_00000045000000450000004500000045_0_0
0_00000c5_00000000000000000000000000000000_000000c5000000c5000000c5000000c5_0_1
0_0000045_00000000000000000000000000000000_00000045000000450000004500000045_0_0
0_0000085_00000000000000000000000000000000_00000085000000850000008500000085_0_1
// dirty line in set 0a pushed out
0_002000a_00000000000000000000000000000000_0002000a0002000a0002000a0002000a_0_1
0_003000a_00000000000000000000000000000000_0003000a0003000a0003000a0003000a_1_1
0_000100a_00000000000000000000000000000000_0123456789abcdef0011223344556677_0_1
// write miss in set 11
1_0000011_f0e1d2c3b4a5968778695a4b3c2d1e0f_00000000000000000000000000000000_0_1
0_0000011_00000000000000000000000000000000_f0e1d2c3b4a5968778695a4b3c2d1e0f_0_0
0_0001011_00000000000000000000000000000000_00001011000010110000101100001011_0_1
0_0002011_00000000000000000000000000000000_00002011000020110000201100002011_1_1
0_0000011_00000000000000000000000000000000_f0e1d2c3b4a5968778695a4b3c2d1e0f_0_1
// second write-back of the same address
1_000100a_55aa55aa66bb66bb77cc77cc88dd88dd_00000000000000000000000000000000_0_0
0_002000a_00000000000000000000000000000000_0002000a0002000a0002000a0002000a_0_1
0_003000a_00000000000000000000000000000000_0003000a0003000a0003000a0003000a_1_1
0_000100a_00000000000000000000000000000000_55aa55aa66bb66bb77cc77cc88dd88dd_0_1
0_ffffc00_00000000000000000000000000000000_0ffffc000ffffc000ffffc000ffffc00_0_1

/* tests/tb_l2_cache.sv */
`timescale 1ns/1ps

module tb_l2_cache
    import cache_pkg::*;
();

    localparam int NUM_SETS = 64;
    localparam int MAX_OPS  = 64;
    localparam int REC_W    = 296;

    logic  clk;
    logic  proc_reset;
    logic  proc_read;
    logic  proc_write;
    addr_t proc_addr;
    line_t proc_wdata;
    line_t proc_rdata;
    logic  proc_stall;
    logic  mem_read;
    logic  mem_write;
    addr_t mem_addr;
    line_t mem_wdata;
    line_t mem_rdata;
    logic  mem_ready;

    // op, addr, wdata, expected rdata, expected writes, expected reads
    logic [REC_W-1:0] stim [MAX_OPS];
    int num_ops;
    int cycles;
    int cycle_limit;
    int errors;
    int checks;
    int wr_count;
    int rd_count;

    // memory model
    addr_t       wr_addr_q [$];
    line_t       wr_data_q [$];
    logic [15:0] lfsr;
    logic        active;
    int          wait_cnt;
    logic        hold_valid;
    logic [1:0]  held_ctrl;
    addr_t       held_addr;
    line_t       held_wdata;

    l2_cache #(.NUM_SETS(NUM_SETS)) u_dut
    (
        .clk        (clk),
        .proc_reset (proc_reset),
        .proc_read  (proc_read),
        .proc_write (proc_write),
        .proc_addr  (proc_addr),
        .proc_wdata (proc_wdata),
        .proc_rdata (proc_rdata),
        .proc_stall (proc_stall),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_rdata  (mem_rdata),
        .mem_ready  (mem_ready)
    );

    always #20 clk = ~clk;

    // fibonacci lfsr with taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // two bits give 0 to 3 wait cycles
    function automatic int next_delay();
        int d;
        d = 0;
        for (int i = 0; i < 2; i++)
        begin
            lfsr = lfsr_next(lfsr);
            d = (d << 1) | int'(lfsr[0]);
        end
        return d;
    endfunction

    function automatic line_t fill_pattern(input addr_t a);
        return {4{{4'h0, a}}};
    endfunction

    // latest accepted write wins
    function automatic line_t mem_lookup(input addr_t a);
        line_t d;
        d = fill_pattern(a);
        foreach (wr_addr_q[i])
        begin
            if (wr_addr_q[i] == a)
            begin
                d = wr_data_q[i];
            end
        end
        return d;
    endfunction

    // sample at the falling edge and answer 2 ns after the rising edge
    always
    begin
        @(negedge clk);
        if (!proc_reset)
        begin
            if (hold_valid)
            begin
                checks++;
                if ({mem_read, mem_write} !== held_ctrl || mem_addr !== held_addr ||
                    mem_wdata !== held_wdata || proc_stall !== 1'b1)
                begin
                    errors++;
                    $display("mismatch at time %0t: memory request moved while waiting", $time);
                end
            end
            hold_valid = active && !mem_ready;
            held_ctrl  = {mem_read, mem_write};
            held_addr  = mem_addr;
            held_wdata = mem_wdata;
            if (active && mem_ready)
            begin
                if (mem_write)
                begin
                    wr_count++;
                    wr_addr_q.push_back(mem_addr);
                    wr_data_q.push_back(mem_wdata);
                end
                else
                begin
                    rd_count++;
                    checks++;
                    if (mem_addr !== proc_addr)
                    begin
                        errors++;
                        $display("mismatch at time %0t: refill address %h, expected %h",
                                 $time, mem_addr, proc_addr);
                    end
                end
                active = 1'b0;
            end
        end
        @(posedge clk);
        #2;
        if (proc_reset)
        begin
            mem_ready  = 1'b0;
            active     = 1'b0;
            hold_valid = 1'b0;
        end
        else
        begin
            if (!active && (mem_read || mem_write))
            begin
                active   = 1'b1;
                wait_cnt = next_delay();
            end
            if (active)
            begin
                mem_ready = (wait_cnt == 0);
                if (wait_cnt > 0)
                begin
                    wait_cnt--;
                end
                mem_rdata = mem_lookup(mem_addr);
            end
            else
            begin
                mem_ready = 1'b0;
            end
        end
    end

    always @(posedge clk)
    begin
        cycles++;
        if (cycles >= cycle_limit)
        begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    // present one operation and wait for the stall to drop
    task automatic run_op(input logic [REC_W-1:0] rec, input int n);
        logic  is_write;
        logic  first;
        logic  done;
        line_t exp_rdata;
        line_t got;
        int    exp_wr;
        int    exp_rd;
        is_write  = rec[REC_W-4];
        exp_rdata = rec[135:8];
        exp_wr    = int'(rec[7:4]);
        exp_rd    = int'(rec[3:0]);
        wr_count  = 0;
        rd_count  = 0;
        proc_read  = !is_write;
        proc_write = is_write;
        proc_addr  = rec[291:264];
        proc_wdata = rec[263:136];
        first = 1'b1;
        done  = 1'b0;
        got   = '0;
        while (!done)
        begin
            @(negedge clk);
            if (first && exp_wr == 0 && exp_rd == 0)
            begin
                checks++;
                if (proc_stall)
                begin
                    errors++;
                    $display("mismatch at time %0t: op %0d stalled on a hit", $time, n);
                end
            end
            if (!proc_stall)
            begin
                done = 1'b1;
                got  = proc_rdata;
            end
            first = 1'b0;
        end
        @(posedge clk);
        #2;
        proc_read  = 1'b0;
        proc_write = 1'b0;
        checks += 2;
        if (!is_write && got !== exp_rdata)
        begin
            errors++;
            $display("mismatch at time %0t: op %0d read %h, expected %h",
                     $time, n, got, exp_rdata);
        end
        if (wr_count != exp_wr || rd_count != exp_rd)
        begin
            errors++;
            $display("mismatch at time %0t: op %0d saw %0d writes %0d reads, expected %0d %0d",
                     $time, n, wr_count, rd_count, exp_wr, exp_rd);
        end
    endtask

    initial
    begin
        proc_reset = 1'b1;
        clk        = 1'b0;
        proc_read  = 1'b0;
        proc_write = 1'b0;
        proc_addr  = '0;
        proc_wdata = '0;
        mem_rdata  = '0;
        mem_ready  = 1'b0;
        errors     = 0;
        checks     = 0;
        cycles     = 0;
        wr_count   = 0;
        rd_count   = 0;
        lfsr       = 16'd60;
        active     = 1'b0;
        hold_valid = 1'b0;
        wait_cnt   = 0;
        // unused entries keep op f as the end marker
        for (int i = 0; i < MAX_OPS; i++)
        begin
            stim[i] = '1;
        end
        $readmemh("tests/cache_stimulus.txt", stim);
        num_ops = 0;
        while (num_ops < MAX_OPS && stim[num_ops][REC_W-1 -: 4] != 4'hf)
        begin
            num_ops++;
        end
        cycle_limit = num_ops * 20 + 100;
        repeat (10) @(posedge clk);
        #2;
        proc_reset = 1'b0;
        if (num_ops == 0)
        begin
            errors++;
            $display("no operations were found in the stimulus file");
        end
        for (int i = 0; i < num_ops; i++)
        begin
            run_op(stim[i], i);
        end
        $display("operations: %0d, checks: %0d, errors: %0d", num_ops, checks, errors);
        if (errors == 0)
        begin
            $display("STATUS: PASS");
        end
        else
        begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

/* design/l2_cache.sv */
`timescale 1ns/1ps

module l2_cache
    import cache_pkg::*;
#(
    parameter int NUM_SETS = 64
)
(
    input  logic  clk,
    input  logic  proc_reset,

    // processor port
    input  logic  proc_read,
    input  logic  proc_write,
    input  addr_t proc_addr,
    input  line_t proc_wdata,
    output line_t proc_rdata,
    output logic  proc_stall,

    // memory port
    output logic  mem_read,
    output logic  mem_write,
    output addr_t mem_addr,
    output line_t mem_wdata,
    input  line_t mem_rdata,
    input  logic  mem_ready
);

    array_if #(.NUM_SETS(NUM_SETS)) bus ();

    assign bus.addr   = proc_addr;
    assign bus.wdata  = proc_wdata;
    assign proc_rdata = bus.rd_line;

    cache_ctrl u_ctrl
    (
        .clk        (clk),
        .proc_reset (proc_reset),
        .proc_read  (proc_read),
        .proc_write (proc_write),
        .proc_addr  (proc_addr),
        .proc_stall (proc_stall),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_rdata  (mem_rdata),
        .mem_ready  (mem_ready),
        .bus        (bus.ctrl)
    );

    tag_array #(.NUM_SETS(NUM_SETS)) u_tags
    (
        .clk        (clk),
        .proc_reset (proc_reset),
        .bus        (bus.tags)
    );

    data_array #(.NUM_SETS(NUM_SETS)) u_data
    (
        .clk        (clk),
        .proc_reset (proc_reset),
        .bus        (bus.data)
    );

endmodule

/* design/cache_ctrl.sv */
`timescale 1ns/1ps

module cache_ctrl
    import cache_pkg::*;
(
    input  logic  clk,
    input  logic  proc_reset,
    input  logic  proc_read,
    input  logic  proc_write,
    input  addr_t proc_addr,
    output logic  proc_stall,
    output logic  mem_read,
    output logic  mem_write,
    output addr_t mem_addr,
    output line_t mem_wdata,
    input  line_t mem_rdata,
    input  logic  mem_ready,
    array_if.ctrl bus
);
    // tag width follows the array geometry
    localparam int TAG_W = $bits(bus.victim_tag);
    localparam int IDX_W = ADDR_W - TAG_W;

    cache_state_t state;
    cache_state_t state_nxt;

    logic  req;
    logic  lookup;
    logic  miss;
    addr_t wb_addr;

    assign req    = proc_read | proc_write;
    assign lookup = (state == ST_LOOKUP);
    assign miss   = req & ~bus.hit;

    // victim line goes back to its own address
    assign wb_addr = {bus.victim_tag, proc_addr[IDX_W-1:0]};

    // next state
    always_comb
    begin
        state_nxt = state;
        case (state)
            ST_LOOKUP:
            begin
                if (miss)
                begin
                    state_nxt = bus.victim_dirty ? ST_WRITEBACK : ST_REFILL;
                end
            end
            ST_WRITEBACK:
            begin
                if (mem_ready)
                begin
                    state_nxt = ST_REFILL;
                end
            end
            ST_REFILL:
            begin
                if (mem_ready)
                begin
                    state_nxt = ST_LOOKUP;
                end
            end
            default:
            begin
                state_nxt = ST_LOOKUP;
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (proc_reset)
        begin
            state <= ST_LOOKUP;
        end
        else
        begin
            state <= state_nxt;
        end
    end

    // processor side
    assign proc_stall = req & (~bus.hit | ~lookup);

    // array update strobes
    assign bus.touch     = lookup & proc_read & bus.hit;
    assign bus.write_hit = lookup & proc_write & bus.hit;
    assign bus.fill      = (state == ST_REFILL) & mem_ready;
    assign bus.fill_line = mem_rdata;

    // memory side, held steady until mem_ready
    always_comb
    begin
        mem_read  = (state == ST_REFILL);
        mem_write = (state == ST_WRITEBACK);
        mem_wdata = bus.victim_line;
        if (state == ST_WRITEBACK)
        begin
            mem_addr = wb_addr;
        end
        else
        begin
            mem_addr = proc_addr;
        end
    end

endmodule

/* design/data_array.sv */
`timescale 1ns/1ps

module data_array
    import cache_pkg::*;
#(
    parameter int NUM_SETS = 64
)
(
    input  logic  clk,
    input  logic  proc_reset,
    array_if.data bus
);
    localparam int IDX_W = $clog2(NUM_SETS);

    line_t            line_mem [NUM_SETS][NUM_WAYS];
    logic [IDX_W-1:0] idx;

    assign idx = bus.addr[IDX_W-1:0];

    // hit line for the processor, victim line for write-back
    assign bus.rd_line     = line_mem[idx][bus.hit_way];
    assign bus.victim_line = line_mem[idx][bus.victim_way];

    always_ff @(posedge clk)
    begin
        if (proc_reset)
        begin
            for (int s = 0; s < NUM_SETS; s++)
            begin
                for (int w = 0; w < NUM_WAYS; w++)
                begin
                    line_mem[s][w] <= '0;
                end
            end
        end
        else if (bus.fill)
        begin
            line_mem[idx][bus.victim_way] <= bus.fill_line;
        end
        else if (bus.write_hit)
        begin
            // whole line replaced by processor data
            line_mem[idx][bus.hit_way] <= bus.wdata;
        end
    end

endmodule

/* design/tag_array.sv */
`timescale 1ns/1ps

module tag_array
    import cache_pkg::*;
#(
    parameter int NUM_SETS = 64
)
(
    input  logic  clk,
    input  logic  proc_reset,
    array_if.tags bus
);
    localparam int IDX_W = $clog2(NUM_SETS);
    localparam int TAG_W = ADDR_W - IDX_W;

    logic [TAG_W-1:0]    tag_mem   [NUM_SETS][NUM_WAYS];
    logic [NUM_WAYS-1:0] valid_mem [NUM_SETS];
    logic [NUM_WAYS-1:0] dirty_mem [NUM_SETS];
    way_t                lru_mem   [NUM_SETS];

    logic [IDX_W-1:0]    idx;
    logic [TAG_W-1:0]    tag;
    logic [NUM_WAYS-1:0] way_hit;
    way_t                hit_w;
    way_t                victim;

    assign idx = bus.addr[IDX_W-1:0];
    assign tag = bus.addr[ADDR_W-1:IDX_W];

    // compare against every valid way of the set
    always_comb
    begin
        hit_w = '0;
        for (int w = 0; w < NUM_WAYS; w++)
        begin
            way_hit[w] = valid_mem[idx][w] && (tag_mem[idx][w] == tag);
            if (way_hit[w])
            begin
                hit_w = way_t'(w);
            end
        end
    end

    // lru bit names the way to replace next
    assign victim = lru_mem[idx];

    assign bus.hit          = |way_hit;
    assign bus.hit_way      = hit_w;
    assign bus.victim_way   = victim;
    assign bus.victim_dirty = valid_mem[idx][victim] & dirty_mem[idx][victim];
    assign bus.victim_tag   = tag_mem[idx][victim];

    // state bits per set
    always_ff @(posedge clk)
    begin
        if (proc_reset)
        begin
            for (int s = 0; s < NUM_SETS; s++)
            begin
                valid_mem[s] <= '0;
                dirty_mem[s] <= '0;
                lru_mem[s]   <= '0;
            end
        end
        else if (bus.fill)
        begin
            // refilled line starts clean
            valid_mem[idx][victim] <= 1'b1;
            dirty_mem[idx][victim] <= 1'b0;
            lru_mem[idx]           <= ~victim;
        end
        else if (bus.touch || bus.write_hit)
        begin
            lru_mem[idx] <= ~hit_w;
            if (bus.write_hit)
            begin
                dirty_mem[idx][hit_w] <= 1'b1;
            end
        end
    end

    // tag storage, only written on refill
    always_ff @(posedge clk)
    begin
        if (bus.fill)
        begin
            tag_mem[idx][victim] <= tag;
        end
    end

endmodule

/* design/array_if.sv */
`timescale 1ns/1ps

interface array_if
    import cache_pkg::*;
#(
    parameter int NUM_SETS = 64
)
();
    localparam int IDX_W = $clog2(NUM_SETS);
    localparam int TAG_W = ADDR_W - IDX_W;

    // lookup address and write data from the processor port
    addr_t            addr;
    line_t            wdata;

    // tag side results
    logic             hit;
    way_t             hit_way;
    way_t             victim_way;
    logic             victim_dirty;
    logic [TAG_W-1:0] victim_tag;

    // data side results
    line_t            rd_line;
    line_t            victim_line;

    // update strobes from the controller
    logic             touch;
    logic             write_hit;
    logic             fill;
    line_t            fill_line;

    modport ctrl
    (
        input  hit,
        input  victim_dirty,
        input  victim_tag,
        input  victim_line,
        output touch,
        output write_hit,
        output fill,
        output fill_line
    );

    modport tags
    (
        input  addr,
        input  touch,
        input  write_hit,
        input  fill,
        output hit,
        output hit_way,
        output victim_way,
        output victim_dirty,
        output victim_tag
    );

    modport data
    (
        input  addr,
        input  write_hit,
        input  fill,
        input  hit_way,
        input  victim_way,
        input  wdata,
        input  fill_line,
        output rd_line,
        output victim_line
    );

endinterface

/* design/cache_pkg.sv */
package cache_pkg;

    // line address and line width
    localparam int ADDR_W = 28;
    localparam int DATA_W = 128;

    // fixed by the single lru bit per set
    localparam int NUM_WAYS = 2;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] line_t;
    typedef logic              way_t;

    // controller states
    typedef enum logic [1:0]
    {
        ST_LOOKUP,
        ST_WRITEBACK,
        ST_REFILL
    } cache_state_t;

endpackage
